//--- Bender.yml
package:
  name: ht_write

sources:
  - include_dirs:
      - .
    files:
      - ht_pkg.sv
      - ht_bucket_search.sv
      - ht_fastforward.sv
      - ht_write_ctrl.sv
      - ht_write_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_ht_write.sv

//--- ht_bucket_search.sv
`timescale 1ns/1ps
`default_nettype none

`include "ht_macros.svh"

module ht_bucket_search (
	input  wire                          clk,
	input  wire                          rst_regd,
	input  wire                          line_load,
	input  wire                          line_sel,
	input  wire ht_pkg::ht_line_t        line_data,
	input  wire [`HT_KEY_WIDTH-1:0]      search_key,
	output logic                         match_found,
	output logic                         match_bucket,
	output ht_pkg::ht_slot_t             match_slot,
	output logic                         empty_found,
	output logic                         empty_bucket,
	output ht_pkg::ht_slot_t             empty_slot,
	output ht_pkg::ht_line_t             sel_line
);
	import ht_pkg::*;

	localparam int ENTRY_W = $bits(ht_entry_t);

	ht_line_t line_r [2];
	logic [1:0] m_hit;
	logic [1:0] e_hit;
	ht_slot_t m_slot [2];
	ht_slot_t e_slot [2];

	logic cur_match;
	logic cur_empty;
	ht_slot_t cur_mslot;
	ht_slot_t cur_eslot;

	// all slots in parallel, walking down so the lowest index wins
	always_comb begin
		cur_match = 1'b0;
		cur_empty = 1'b0;
		cur_mslot = '0;
		cur_eslot = '0;
		for (int i = `HT_SLOTS - 1; i >= 0; i--) begin
			if (line_data[i*ENTRY_W +: `HT_KEY_WIDTH] == search_key && search_key != '0) begin
				cur_match = 1'b1;
				cur_mslot = ht_slot_t'(i);
			end
			if (line_data[i*ENTRY_W +: `HT_KEY_WIDTH] == '0) begin
				cur_empty = 1'b1;
				cur_eslot = ht_slot_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_regd) begin
			m_hit <= '0;
			e_hit <= '0;
		end else if (line_load) begin
			m_hit[line_sel] <= cur_match;
			e_hit[line_sel] <= cur_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (line_load) begin
			line_r[line_sel] <= line_data;
			m_slot[line_sel] <= cur_mslot;
			e_slot[line_sel] <= cur_eslot;
		end
	end

	// hash1 bucket has priority over hash2
	assign match_found  = |m_hit;
	assign match_bucket = !m_hit[0];
	assign match_slot   = m_hit[0] ? m_slot[0] : m_slot[1];
	assign empty_found  = |e_hit;
	assign empty_bucket = !e_hit[0];
	assign empty_slot   = e_hit[0] ? e_slot[0] : e_slot[1];

	always_comb begin
		if (match_found) begin
			sel_line = line_r[match_bucket];
		end else if (empty_found) begin
			sel_line = line_r[empty_bucket];
		end else begin
			sel_line = line_r[0];
		end
	end

endmodule

`default_nettype wire

//--- ht_fastforward.sv
`timescale 1ns/1ps
`default_nettype none

`include "ht_macros.svh"

module ht_fastforward (
	input  wire                          clk,
	input  wire                          rst_regd,
	input  wire                          ff_start,
	input  wire ht_pkg::ht_addr_t        hash1,
	input  wire ht_pkg::ht_addr_t        hash2,
	output logic                         ff_done,
	output logic [1:0]                   ff_hit,
	output ht_pkg::ht_line_t             ff_line,
	input  wire                          ff_push,
	input  wire ht_pkg::ht_addr_t        ff_push_addr,
	input  wire ht_pkg::ht_line_t        ff_push_line,
	output logic                         ff_full
);
	import ht_pkg::*;

	localparam int DEPTH = 2 ** `HT_FF_BITS;

	typedef logic [`HT_FF_BITS-1:0] ptr_t;

	ht_line_t line_mem [DEPTH];
	ht_addr_t addr_mem [DEPTH];

	ptr_t head;
	ptr_t tail;
	ptr_t count;
	ptr_t pos;
	ptr_t remaining;
	ptr_t hit_pos;
	logic busy;
	ht_addr_t h1_r;
	ht_addr_t h2_r;

	// one bit per push, the oldest entry retires when its bit falls out
	logic [`HT_MEM_WRITE_WAIT-1:0] delayer;

	logic retire;
	logic cmp_valid;
	logic cmp_h1;
	logic cmp_h2;

	assign ff_full   = (count == ptr_t'(DEPTH - 1));
	assign retire    = delayer[`HT_MEM_WRITE_WAIT-1] && (count != '0);
	assign cmp_valid = busy && (remaining != '0);
	assign cmp_h1    = (addr_mem[pos] == h1_r);
	assign cmp_h2    = (addr_mem[pos] == h2_r);

	// --------------------------------------------------
	// ring pointers and scan control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			delayer <= '0;
			busy <= 1'b0;
			pos <= '0;
			remaining <= '0;
			ff_done <= 1'b0;
			ff_hit <= 2'd0;
		end else begin
			delayer <= {delayer[`HT_MEM_WRITE_WAIT-2:0], ff_push};
			if (ff_push) begin
				head <= head + 1'b1;
			end
			if (retire) begin
				tail <= tail + 1'b1;
			end
			if (ff_push && !retire) begin
				count <= count + 1'b1;
			end else if (!ff_push && retire) begin
				count <= count - 1'b1;
			end

			ff_done <= 1'b0;
			if (ff_start) begin
				busy <= 1'b1;
				pos <= tail;
				remaining <= count;
				ff_hit <= 2'd0;
			end else if (cmp_valid) begin
				// later entries overwrite, so the newest match survives
				pos <= pos + 1'b1;
				remaining <= remaining - 1'b1;
				if (cmp_h1) begin
					ff_hit <= 2'd1;
				end else if (cmp_h2) begin
					ff_hit <= 2'd2;
				end
			end else if (busy) begin
				busy <= 1'b0;
				ff_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ff_push) begin
			line_mem[head] <= ff_push_line;
			addr_mem[head] <= ff_push_addr;
		end
		if (ff_start) begin
			h1_r <= hash1;
			h2_r <= hash2;
		end
		if (cmp_valid && (cmp_h1 || cmp_h2)) begin
			hit_pos <= pos;
		end
		if (busy && !cmp_valid) begin
			ff_line <= line_mem[hit_pos];
		end
	end

endmodule

`default_nettype wire

//--- ht_macros.svh
`ifndef HT_MACROS_SVH
`define HT_MACROS_SVH

// key and memory geometry
`define HT_KEY_WIDTH 64
`define HT_LINE_WIDTH 512
`define HT_ADDR_WIDTH 21

// entries per bucket line
`define HT_SLOTS 4

// forwarding buffer depth (log2) and write latency cover
`define HT_FF_BITS 5
`define HT_MEM_WRITE_WAIT 512

`endif

//--- ht_pkg.sv
`default_nettype none

`include "ht_macros.svh"

package ht_pkg;

	typedef enum logic [3:0] {
		GET    = 4'h0,
		SETCUR = 4'h1,
		DELCUR = 4'h2,
		IGNORE = 4'hf
	} ht_op_e;

	typedef enum logic [1:0] {
		OK   = 2'd0,
		MISS = 2'd1,
		FULL = 2'd2
	} ht_status_e;

	// value pointer, address in the low bits
	typedef struct packed {
		logic [15:0] len;
		logic [31:0] addr;
	} ht_valptr_t;

	// key sits at bit 0 of each slot, zero key means empty
	typedef struct packed {
		ht_valptr_t                valptr;
		logic [`HT_KEY_WIDTH-1:0] key;
	} ht_entry_t;

	typedef logic [`HT_LINE_WIDTH-1:0] ht_line_t;
	typedef logic [$clog2(`HT_SLOTS)-1:0] ht_slot_t;
	typedef logic [`HT_ADDR_WIDTH-1:0] ht_addr_t;

endpackage

`default_nettype wire

//--- ht_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ht_macros.svh"

module ht_write_ctrl (
	input  wire                          clk,
	input  wire                          rst_regd,

	input  wire [`HT_KEY_WIDTH-1:0]      in_key,
	input  wire ht_pkg::ht_op_e          in_op,
	input  wire ht_pkg::ht_addr_t        in_hash1,
	input  wire ht_pkg::ht_addr_t        in_hash2,
	input  wire [15:0]                   in_vallen,
	input  wire                          in_valid,
	output logic                         in_ready,

	input  wire ht_pkg::ht_line_t        rd_data,
	input  wire                          rd_valid,
	output logic                         rd_ready,

	input  wire [31:0]                   malloc_pointer,
	input  wire                          malloc_valid,
	output logic                         malloc_ready,

	output logic [`HT_KEY_WIDTH-1:0]     out_key,
	output ht_pkg::ht_op_e               out_op,
	output ht_pkg::ht_valptr_t           out_valptr,
	output ht_pkg::ht_status_e           out_status,
	output logic                         out_valid,
	input  wire                          out_ready,

	output ht_pkg::ht_line_t             wr_data,
	output logic                         wr_valid,
	input  wire                          wr_ready,
	output logic [31:0]                  wrcmd_data,
	output logic                         wrcmd_valid,
	input  wire                          wrcmd_ready,

	output logic [31:0]                  free_pointer,
	output logic [15:0]                  free_size,
	output logic                         free_valid,
	input  wire                          free_ready,

	output logic                         ff_start,
	input  wire                          ff_done,
	input  wire [1:0]                    ff_hit,
	input  wire ht_pkg::ht_line_t        ff_line,
	input  wire                          ff_full,
	output logic                         ff_push,
	output ht_pkg::ht_addr_t             ff_push_addr,
	output ht_pkg::ht_line_t             ff_push_line,

	output logic                         line_load,
	output logic                         line_sel,
	output ht_pkg::ht_line_t             line_data,
	output logic [`HT_KEY_WIDTH-1:0]     search_key,
	input  wire                          match_found,
	input  wire                          match_bucket,
	input  wire ht_pkg::ht_slot_t        match_slot,
	input  wire                          empty_found,
	input  wire                          empty_bucket,
	input  wire ht_pkg::ht_slot_t        empty_slot,
	input  wire ht_pkg::ht_line_t        sel_line
);
	import ht_pkg::*;

	localparam int ENTRY_W = $bits(ht_entry_t);

	typedef enum logic [2:0] {
		st_idle,
		st_check_ff,
		st_read_one,
		st_read_two,
		st_choose,
		st_decide,
		st_write_out,
		st_send_out
	} state_e;

	state_e state;

	logic [`HT_KEY_WIDTH-1:0] req_key;
	ht_op_e req_op;
	ht_addr_t req_hash1;
	ht_addr_t req_hash2;
	logic [15:0] req_vallen;
	logic [31:0] malloc_reg;

	logic key_hit;
	logic is_full;
	logic tgt_bucket;
	ht_slot_t tgt_slot;
	ht_line_t tgt_line;
	ht_addr_t tgt_addr;
	ht_entry_t old_entry;
	ht_entry_t new_entry;
	ht_valptr_t new_ptr;
	ht_valptr_t resp_ptr;
	ht_status_e resp_status;
	ht_line_t merged_line;

	logic accept;
	logic malloc_ok;
	logic take_one;
	logic take_two;
	logic need_free;
	logic to_write;
	logic decide_go;
	logic wo_fire;
	logic send_fire;

	assign accept    = (state == st_idle) && in_valid;
	// a SETCUR holds its first read until a pointer is on offer
	assign malloc_ok = (req_op != SETCUR) || malloc_valid;
	assign take_one  = (state == st_read_one) && rd_valid && malloc_ok;
	assign take_two  = (state == st_read_two) && rd_valid && !rd_ready;
	assign line_load = take_one || take_two;
	assign line_sel  = (state == st_read_two);
	assign search_key = req_key;

	// a forwarded bucket replaces the possibly stale memory copy
	assign line_data = (ff_hit == (line_sel ? 2'd2 : 2'd1)) ? ff_line : rd_data;

	assign tgt_addr  = tgt_bucket ? req_hash2 : req_hash1;
	assign old_entry = tgt_line[tgt_slot*ENTRY_W +: ENTRY_W];
	assign new_ptr   = {req_vallen, malloc_reg};

	always_comb begin
		merged_line = tgt_line;
		merged_line[tgt_slot*ENTRY_W +: ENTRY_W] = new_entry;
	end

	assign need_free = key_hit && (req_op == SETCUR || req_op == DELCUR);
	assign to_write  = (req_op == SETCUR && !is_full) || (req_op == DELCUR && key_hit);
	assign decide_go = (state == st_decide) && (!need_free || free_ready);
	assign wo_fire   = (state == st_write_out) && wr_ready && wrcmd_ready && out_ready && !ff_full;
	assign send_fire = (state == st_send_out) && out_ready;

	assign ff_push      = wo_fire;
	assign ff_push_addr = tgt_addr;
	assign ff_push_line = merged_line;

	// --------------------------------------------------
	// request FSM and handshakes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_regd) begin
			state <= st_idle;
			in_ready <= 1'b0;
			rd_ready <= 1'b0;
			malloc_ready <= 1'b0;
			ff_start <= 1'b0;
			out_valid <= 1'b0;
			wr_valid <= 1'b0;
			wrcmd_valid <= 1'b0;
			free_valid <= 1'b0;
		end else begin
			in_ready <= 1'b0;
			rd_ready <= 1'b0;
			malloc_ready <= 1'b0;
			ff_start <= 1'b0;
			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
			if (wr_valid && wr_ready) begin
				wr_valid <= 1'b0;
			end
			if (wrcmd_valid && wrcmd_ready) begin
				wrcmd_valid <= 1'b0;
			end
			if (free_valid && free_ready) begin
				free_valid <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (accept) begin
						in_ready <= 1'b1;
						if (in_op == IGNORE) begin
							state <= st_send_out;
						end else begin
							ff_start <= 1'b1;
							state <= st_check_ff;
						end
					end
				end
				st_check_ff: begin
					if (ff_done) begin
						state <= st_read_one;
					end
				end
				st_read_one: begin
					if (take_one) begin
						rd_ready <= 1'b1;
						state <= st_read_two;
					end
				end
				st_read_two: begin
					if (take_two) begin
						rd_ready <= 1'b1;
						state <= st_choose;
					end
				end
				st_choose: state <= st_decide;
				st_decide: begin
					if (decide_go) begin
						malloc_ready <= (req_op == SETCUR) && !is_full;
						if (need_free) begin
							free_valid <= 1'b1;
						end
						state <= to_write ? st_write_out : st_send_out;
					end
				end
				st_write_out: begin
					if (wo_fire) begin
						wr_valid <= 1'b1;
						wrcmd_valid <= 1'b1;
						out_valid <= 1'b1;
						state <= st_idle;
					end
				end
				st_send_out: begin
					if (send_fire) begin
						out_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// --------------------------------------------------
	// request, target entry and response data
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			req_key <= in_key;
			req_op <= in_op;
			req_hash1 <= in_hash1;
			req_hash2 <= in_hash2;
			req_vallen <= in_vallen;
			resp_ptr <= '0;
			resp_status <= OK;
		end
		if (take_one) begin
			malloc_reg <= malloc_pointer;
		end

		// key match first, then the first empty slot
		if (state == st_choose) begin
			tgt_line <= sel_line;
			key_hit <= match_found;
			is_full <= !match_found && !empty_found;
			tgt_bucket <= match_found ? match_bucket : empty_bucket;
			tgt_slot <= match_found ? match_slot : empty_slot;
		end

		if (decide_go) begin
			if (need_free) begin
				free_pointer <= old_entry.valptr.addr;
				free_size <= {old_entry.valptr.len[12:0], 3'b000};
			end
			case (req_op)
				GET: begin
					resp_ptr <= key_hit ? old_entry.valptr : '0;
					resp_status <= key_hit ? OK : MISS;
				end
				SETCUR: begin
					new_entry <= {new_ptr, req_key};
					resp_ptr <= is_full ? '0 : new_ptr;
					resp_status <= is_full ? FULL : OK;
				end
				DELCUR: begin
					new_entry <= '0;
					resp_ptr <= key_hit ? old_entry.valptr : '0;
					resp_status <= key_hit ? OK : MISS;
				end
				default: resp_ptr <= '0;
			endcase
		end

		if (wo_fire) begin
			wr_data <= merged_line;
			wrcmd_data <= {{(32 - `HT_ADDR_WIDTH){1'b0}}, tgt_addr};
		end
		if (wo_fire || send_fire) begin
			out_key <= req_key;
			out_op <= req_op;
			out_valptr <= resp_ptr;
			out_status <= resp_status;
		end
	end

endmodule

`default_nettype wire

//--- ht_write_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ht_macros.svh"

module ht_write_top (
	input  wire                          clk,
	input  wire                          rst_regd,

	input  wire [`HT_KEY_WIDTH-1:0]      in_key,
	input  wire ht_pkg::ht_op_e          in_op,
	input  wire ht_pkg::ht_addr_t        in_hash1,
	input  wire ht_pkg::ht_addr_t        in_hash2,
	input  wire [15:0]                   in_vallen,
	input  wire                          in_valid,
	output wire                          in_ready,

	input  wire ht_pkg::ht_line_t        rd_data,
	input  wire                          rd_valid,
	output wire                          rd_ready,

	input  wire [31:0]                   malloc_pointer,
	input  wire                          malloc_valid,
	output wire                          malloc_ready,

	output wire [`HT_KEY_WIDTH-1:0]      out_key,
	output wire ht_pkg::ht_op_e          out_op,
	output wire ht_pkg::ht_valptr_t      out_valptr,
	output wire ht_pkg::ht_status_e      out_status,
	output wire                          out_valid,
	input  wire                          out_ready,

	output wire ht_pkg::ht_line_t        wr_data,
	output wire                          wr_valid,
	input  wire                          wr_ready,
	output wire [31:0]                   wrcmd_data,
	output wire                          wrcmd_valid,
	input  wire                          wrcmd_ready,

	output wire [31:0]                   free_pointer,
	output wire [15:0]                   free_size,
	output wire                          free_valid,
	input  wire                          free_ready
);
	import ht_pkg::*;

	// controller to forwarding buffer
	logic ff_start;
	logic ff_done;
	logic [1:0] ff_hit;
	ht_line_t ff_line;
	logic ff_full;
	logic ff_push;
	ht_addr_t ff_push_addr;
	ht_line_t ff_push_line;

	// controller to bucket search
	logic line_load;
	logic line_sel;
	ht_line_t line_data;
	logic [`HT_KEY_WIDTH-1:0] search_key;
	logic match_found;
	logic match_bucket;
	ht_slot_t match_slot;
	logic empty_found;
	logic empty_bucket;
	ht_slot_t empty_slot;
	ht_line_t sel_line;

	ht_write_ctrl u_ctrl (.*);

	ht_bucket_search u_search (.*);

	// the request hashes are still stable while ff_start pulses
	ht_fastforward u_ff (
		.clk          (clk),
		.rst_regd     (rst_regd),
		.ff_start     (ff_start),
		.hash1        (in_hash1),
		.hash2        (in_hash2),
		.ff_done      (ff_done),
		.ff_hit       (ff_hit),
		.ff_line      (ff_line),
		.ff_push      (ff_push),
		.ff_push_addr (ff_push_addr),
		.ff_push_line (ff_push_line),
		.ff_full      (ff_full)
	);

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_regd
);
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release lands just after the last reset edge, like the other inputs
	initial begin
		rst_regd = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_regd = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_ht_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "ht_macros.svh"

module tb_ht_write;
	import ht_pkg::*;

	localparam int ENTRY_W = $bits(ht_entry_t);
	localparam int NUM_TAB = 22;
	localparam int NUM_RAND = 4;
	localparam int NUM_REQ = NUM_TAB + 2 * NUM_RAND;
	localparam int TIMEOUT = 400 * NUM_REQ;
	localparam int MEM_DELAY = 40;

	typedef struct packed {
		ht_op_e             op;
		logic [63:0]        key;
		ht_addr_t           h1;
		ht_addr_t           h2;
		logic [15:0]        len;
		ht_status_e         status;
		ht_valptr_t         ptr;
	} req_t;

	logic clk;
	logic rst_regd;
	logic [`HT_KEY_WIDTH-1:0] in_key;
	ht_op_e in_op;
	ht_addr_t in_hash1;
	ht_addr_t in_hash2;
	logic [15:0] in_vallen;
	logic in_valid;
	logic in_ready;
	ht_line_t rd_data;
	logic rd_valid;
	logic rd_ready;
	logic [31:0] malloc_pointer;
	logic malloc_valid;
	logic malloc_ready;
	logic [`HT_KEY_WIDTH-1:0] out_key;
	ht_op_e out_op;
	ht_valptr_t out_valptr;
	ht_status_e out_status;
	logic out_valid;
	logic out_ready;
	ht_line_t wr_data;
	logic wr_valid;
	logic wr_ready;
	logic [31:0] wrcmd_data;
	logic wrcmd_valid;
	logic wrcmd_ready;
	logic [31:0] free_pointer;
	logic [15:0] free_size;
	logic free_valid;
	logic free_ready;

	int cycle = 0;
	int errors = 0;

	// memory model state, writes land MEM_DELAY cycles late
	ht_line_t mem [ht_addr_t];
	ht_line_t pend_line [$];
	ht_addr_t pend_addr [$];
	int pend_due [$];
	ht_addr_t cur_h1;
	ht_addr_t cur_h2;
	logic rd_phase;
	logic [31:0] mal_ptr;

	// golden bucket contents and allocator, always up to date
	ht_line_t gold [ht_addr_t];
	logic [31:0] gold_ptr;
	ht_status_e p_status;
	ht_valptr_t p_ptr;
	logic p_write;
	logic p_pop;
	logic p_free;
	ht_addr_t p_addr;
	ht_line_t p_line;
	logic [31:0] p_free_ptr;
	logic [15:0] p_free_size;

	// buckets 0x10 and 0x20 fill up for the FULL case
	req_t req_tab [NUM_TAB] = '{
		'{GET,    64'h11, 21'h10, 21'h110, 16'h00, MISS, 48'h0},
		'{SETCUR, 64'h11, 21'h10, 21'h110, 16'h20, OK,   48'h0020_0000_1000},
		'{GET,    64'h11, 21'h10, 21'h110, 16'h00, OK,   48'h0020_0000_1000},
		'{SETCUR, 64'h11, 21'h10, 21'h110, 16'h30, OK,   48'h0030_0000_1100},
		'{GET,    64'h11, 21'h10, 21'h110, 16'h00, OK,   48'h0030_0000_1100},
		'{DELCUR, 64'h22, 21'h10, 21'h111, 16'h00, MISS, 48'h0},
		'{DELCUR, 64'h11, 21'h10, 21'h110, 16'h00, OK,   48'h0030_0000_1100},
		'{GET,    64'h11, 21'h10, 21'h110, 16'h00, MISS, 48'h0},
		'{IGNORE, 64'h33, 21'h10, 21'h110, 16'h00, OK,   48'h0},
		'{SETCUR, 64'h41, 21'h10, 21'h120, 16'h10, OK,   48'h0010_0000_1200},
		'{SETCUR, 64'h42, 21'h10, 21'h121, 16'h10, OK,   48'h0010_0000_1300},
		'{SETCUR, 64'h43, 21'h10, 21'h122, 16'h10, OK,   48'h0010_0000_1400},
		'{SETCUR, 64'h44, 21'h10, 21'h123, 16'h10, OK,   48'h0010_0000_1500},
		'{SETCUR, 64'h51, 21'h20, 21'h130, 16'h10, OK,   48'h0010_0000_1600},
		'{SETCUR, 64'h52, 21'h20, 21'h131, 16'h10, OK,   48'h0010_0000_1700},
		'{SETCUR, 64'h53, 21'h20, 21'h132, 16'h10, OK,   48'h0010_0000_1800},
		'{SETCUR, 64'h54, 21'h20, 21'h133, 16'h10, OK,   48'h0010_0000_1900},
		'{SETCUR, 64'h61, 21'h10, 21'h20,  16'h10, FULL, 48'h0},
		'{SETCUR, 64'h62, 21'h10, 21'h140, 16'h28, OK,   48'h0028_0000_1a00},
		'{GET,    64'h62, 21'h10, 21'h140, 16'h00, OK,   48'h0028_0000_1a00},
		'{GET,    64'h43, 21'h10, 21'h122, 16'h00, OK,   48'h0010_0000_1400},
		'{GET,    64'h53, 21'h20, 21'h132, 16'h00, OK,   48'h0010_0000_1800}
	};

	tb_clkgen u_clkgen (
		.clk      (clk),
		.rst_regd (rst_regd)
	);

	ht_write_top u_dut (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_eq(input string name, input logic [511:0] got,
			input logic [511:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %0h expected %0h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// --------------------------------------------------
	// expected result from the golden buckets
	// --------------------------------------------------
	task automatic predict_request(input ht_op_e op, input logic [63:0] key,
			input ht_addr_t h1, input ht_addr_t h2, input logic [15:0] len);
		ht_line_t lines [2];
		ht_entry_t ent;
		ht_entry_t old;
		int mb;
		int ms;
		int eb;
		int es;
		int tgt_b;
		int tgt_s;
		lines[0] = gold.exists(h1) ? gold[h1] : '0;
		lines[1] = gold.exists(h2) ? gold[h2] : '0;
		mb = -1;
		ms = 0;
		eb = -1;
		es = 0;
		ent = '0;
		old = '0;
		// hash1 first, lowest slot first
		for (int b = 0; b < 2; b++) begin
			for (int s = 0; s < `HT_SLOTS; s++) begin
				ent = lines[b][s*ENTRY_W +: ENTRY_W];
				if (mb < 0 && ent.key == key) begin
					mb = b;
					ms = s;
				end
				if (eb < 0 && ent.key == '0) begin
					eb = b;
					es = s;
				end
			end
		end
		tgt_b = (mb >= 0) ? mb : eb;
		tgt_s = (mb >= 0) ? ms : es;
		if (mb >= 0) begin
			old = lines[mb][ms*ENTRY_W +: ENTRY_W];
		end
		p_status = OK;
		p_ptr = '0;
		p_write = 1'b0;
		p_pop = 1'b0;
		p_free = 1'b0;
		case (op)
			GET: begin
				p_status = (mb >= 0) ? OK : MISS;
				p_ptr = old.valptr;
			end
			SETCUR: begin
				if (tgt_b < 0) begin
					p_status = FULL;
				end else begin
					p_pop = 1'b1;
					p_write = 1'b1;
					p_free = (mb >= 0);
					p_ptr = {len, gold_ptr};
					ent = {p_ptr, key};
				end
			end
			DELCUR: begin
				if (mb < 0) begin
					p_status = MISS;
				end else begin
					p_ptr = old.valptr;
					p_write = 1'b1;
					p_free = 1'b1;
					ent = '0;
				end
			end
			default: p_status = OK;
		endcase
		if (p_write) begin
			p_addr = (tgt_b == 1) ? h2 : h1;
			p_line = lines[tgt_b];
			p_line[tgt_s*ENTRY_W +: ENTRY_W] = ent;
		end
		p_free_ptr = old.valptr.addr;
		// freed size in bytes, length counts 8-byte words
		p_free_size = old.valptr.len[12:0] * 16'd8;
	endtask

	// --------------------------------------------------
	// one request through the DUT, sampled mid-cycle
	// --------------------------------------------------
	task automatic run_request(input ht_op_e op, input logic [63:0] key, input ht_addr_t h1,
			input ht_addr_t h2, input logic [15:0] len, input ht_status_e exp_status,
			input ht_valptr_t exp_ptr);
		int acc_cnt;
		int rd_cnt;
		int pop_cnt;
		int wr_cnt;
		int cmd_cnt;
		int free_cnt;
		logic got_out;
		logic drop;
		ht_line_t wr_line;
		logic [31:0] wr_addr;
		logic [31:0] fr_ptr;
		logic [15:0] fr_size;
		acc_cnt = 0;
		rd_cnt = 0;
		pop_cnt = 0;
		wr_cnt = 0;
		cmd_cnt = 0;
		free_cnt = 0;
		got_out = 1'b0;
		drop = 1'b0;
		predict_request(op, key, h1, h2, len);
		in_key = key;
		in_op = op;
		in_hash1 = h1;
		in_hash2 = h2;
		in_vallen = len;
		in_valid = 1'b1;
		while (!got_out) begin
			@(negedge clk);
			if (in_ready) begin
				drop = 1'b1;
				acc_cnt++;
			end
			if (rd_ready) begin
				rd_cnt++;
			end
			if (malloc_ready) begin
				pop_cnt++;
			end
			if (free_valid) begin
				free_cnt++;
				fr_ptr = free_pointer;
				fr_size = free_size;
			end
			if (wr_valid) begin
				wr_cnt++;
				wr_line = wr_data;
			end
			if (wrcmd_valid) begin
				cmd_cnt++;
				wr_addr = wrcmd_data;
			end
			if (wr_valid && wrcmd_valid) begin
				pend_line.push_back(wr_data);
				pend_addr.push_back(ht_addr_t'(wrcmd_data));
				pend_due.push_back(cycle + MEM_DELAY);
			end
			if (out_valid) begin
				got_out = 1'b1;
				check_eq("out_key", out_key, key);
				check_eq("out_op", out_op, op);
				check_eq("out_status", out_status, exp_status);
				check_eq("out_valptr", out_valptr, exp_ptr);
			end
			@(posedge clk);
			#2;
			if (drop) begin
				in_valid = 1'b0;
			end
		end
		check_eq("in_ready pulses", acc_cnt, 1);
		check_eq("rd_ready pulses", rd_cnt, (op == IGNORE) ? 0 : 2);
		check_eq("malloc_ready pulses", pop_cnt, p_pop);
		check_eq("free_valid count", free_cnt, p_free);
		check_eq("wr_valid count", wr_cnt, p_write);
		check_eq("wrcmd_valid count", cmd_cnt, p_write);
		if (p_free) begin
			check_eq("free_pointer", fr_ptr, p_free_ptr);
			check_eq("free_size", fr_size, p_free_size);
		end
		if (p_write) begin
			check_eq("wrcmd_data", wr_addr, p_addr);
			check_eq("wr_data", wr_line, p_line);
			gold[p_addr] = p_line;
		end
		if (p_pop) begin
			gold_ptr = gold_ptr + 32'h100;
		end
	endtask

	// memory and allocator models
	always @(posedge clk) begin
		#2;
		while (pend_due.size() > 0 && pend_due[0] <= cycle) begin
			mem[pend_addr[0]] = pend_line[0];
			void'(pend_line.pop_front());
			void'(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end
		if (in_ready) begin
			cur_h1 = in_hash1;
			cur_h2 = in_hash2;
			rd_phase = 1'b0;
		end else if (rd_ready) begin
			rd_phase = !rd_phase;
		end
		rd_data = mem.exists(rd_phase ? cur_h2 : cur_h1) ? mem[rd_phase ? cur_h2 : cur_h1] : '0;
		rd_valid = 1'b1;
		if (malloc_ready) begin
			mal_ptr = mal_ptr + 32'h100;
		end
		malloc_pointer = mal_ptr;
		malloc_valid = 1'b1;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		assert (cycle < TIMEOUT) else begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycle);
			$display("sim failed");
			$fatal(1);
		end
	end

	initial begin
		logic [31:0] seed;
		logic [63:0] rkey;
		ht_addr_t rh1;
		ht_addr_t rh2;
		logic [15:0] rlen;
		in_key = '0;
		in_op = GET;
		in_hash1 = '0;
		in_hash2 = '0;
		in_vallen = '0;
		in_valid = 1'b0;
		rd_data = '0;
		rd_valid = 1'b0;
		malloc_pointer = 32'h1000;
		malloc_valid = 1'b0;
		out_ready = 1'b1;
		wr_ready = 1'b1;
		wrcmd_ready = 1'b1;
		free_ready = 1'b1;
		cur_h1 = '0;
		cur_h2 = '0;
		rd_phase = 1'b0;
		mal_ptr = 32'h1000;
		gold_ptr = 32'h1000;
		seed = 32'd13483;

		@(negedge rst_regd);
		@(posedge clk);
		#2;
		for (int i = 0; i < NUM_TAB; i++) begin
			run_request(req_tab[i].op, req_tab[i].key, req_tab[i].h1, req_tab[i].h2,
				req_tab[i].len, req_tab[i].status, req_tab[i].ptr);
		end

		// random keys into fresh buckets, each read back at once
		for (int i = 0; i < NUM_RAND; i++) begin
			seed = lcg_next(seed);
			rkey[63:32] = seed;
			seed = lcg_next(seed);
			rkey[31:0] = seed | 32'h1;
			rh1 = ht_addr_t'(21'h200 + i);
			rh2 = ht_addr_t'(21'h300 + i);
			rlen = 16'h8 + 16'(i);
			predict_request(SETCUR, rkey, rh1, rh2, rlen);
			run_request(SETCUR, rkey, rh1, rh2, rlen, p_status, p_ptr);
			predict_request(GET, rkey, rh1, rh2, 16'h0);
			run_request(GET, rkey, rh1, rh2, 16'h0, p_status, p_ptr);
		end

		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
ht_pkg.sv
ht_bucket_search.sv
ht_fastforward.sv
ht_write_ctrl.sv
ht_write_top.sv
tb_clkgen.sv
tb_ht_write.sv
